/* hw/ebusPkg.sv */
package ebusPkg;

  localparam int EBUS_WIDTH = 36;
  localparam int DS_WIDTH = 7;
  localparam int SLICE_WIDTH = 6;
  localparam int NUM_SLICES = EBUS_WIDTH / SLICE_WIDTH;

  // ds fields.
  localparam int BOARD_WIDTH = 3;
  localparam int INDEX_WIDTH = 2;
  localparam int NUM_REGS = 1 << INDEX_WIDTH;

  localparam logic [BOARD_WIDTH-1:0] BOARD_APR = 3'd1;
  localparam logic [BOARD_WIDTH-1:0] BOARD_CON = 3'd2;
  localparam logic [BOARD_WIDTH-1:0] BOARD_EDP = 3'd3;  // others unpopulated.

  typedef enum logic
  {
    DIAG_READ  = 1'b0,
    DIAG_WRITE = 1'b1
  } diagOpE;

  // board select, ds bits 6 to 4.
  function automatic logic [BOARD_WIDTH-1:0] dsBoard(input logic [DS_WIDTH-1:0] ds);
    return ds[6:4];
  endfunction

  function automatic diagOpE dsOp(input logic [DS_WIDTH-1:0] ds);
    return diagOpE'(ds[3]);
  endfunction

  // bit 2 is a don't care.
  function automatic logic [INDEX_WIDTH-1:0] dsIndex(input logic [DS_WIDTH-1:0] ds);
    return ds[1:0];
  endfunction

endpackage

/* hw/dpSlice.sv */
`timescale 1ns/10ps

module dpSlice
(
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            loadEn,
  input  logic                            addEn,
  input  logic                            readEn,
  input  logic [ebusPkg::SLICE_WIDTH-1:0] inBits,
  input  logic                            carryIn,
  output logic                            carryOut,
  output logic                            driving,
  output logic [ebusPkg::SLICE_WIDTH-1:0] outBits
);

  logic [ebusPkg::SLICE_WIDTH-1:0] ar;
  logic [ebusPkg::SLICE_WIDTH:0] sum;

  // one extra bit holds the carry.
  assign sum = {1'b0, ar} + {1'b0, inBits} + {{ebusPkg::SLICE_WIDTH{1'b0}}, carryIn};
  assign carryOut = sum[ebusPkg::SLICE_WIDTH];

  assign driving = readEn;
  assign outBits = ar;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      ar <= '0;
    end
    else if (loadEn)
    begin
      ar <= inBits;
    end
    else if (addEn)
    begin
      ar <= sum[ebusPkg::SLICE_WIDTH-1:0];
    end
  end

endmodule

/* hw/diagRegBoard.sv */
`timescale 1ns/10ps

module diagRegBoard
#(
  parameter logic [ebusPkg::BOARD_WIDTH-1:0] boardSel = ebusPkg::BOARD_APR
)
(
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [ebusPkg::DS_WIDTH-1:0]    ds,
  input  logic                            diagStrobe,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  ebusData,
  output logic                            driving,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  data
);

  logic [ebusPkg::EBUS_WIDTH-1:0] regs [ebusPkg::NUM_REGS];
  logic [ebusPkg::INDEX_WIDTH-1:0] index;
  logic selected;
  logic writeHit;

  assign selected = (ebusPkg::dsBoard(ds) == boardSel);
  assign index = ebusPkg::dsIndex(ds);

  // reads are combinational while selected.
  assign driving = selected && (ebusPkg::dsOp(ds) == ebusPkg::DIAG_READ);
  assign data = regs[index];

  assign writeHit = diagStrobe && selected && (ebusPkg::dsOp(ds) == ebusPkg::DIAG_WRITE);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < ebusPkg::NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeHit)
    begin
      regs[index] <= ebusData;  // load at end of strobe.
    end
  end

endmodule

/* hw/edpBoard.sv */
`timescale 1ns/10ps

module edpBoard
(
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [ebusPkg::DS_WIDTH-1:0]    ds,
  input  logic                            diagStrobe,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  ebusData,
  output logic [ebusPkg::NUM_SLICES-1:0]  sliceDriving,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  data
);

  logic [ebusPkg::INDEX_WIDTH-1:0] index;
  logic selected;
  logic isWrite;
  logic loadEn;
  logic addEn;
  logic readEn;
  logic [ebusPkg::NUM_SLICES:0] carry;  // top carry is dropped, add wraps at 2^36.

  assign selected = (ebusPkg::dsBoard(ds) == ebusPkg::BOARD_EDP);
  assign index = ebusPkg::dsIndex(ds);
  assign isWrite = (ebusPkg::dsOp(ds) == ebusPkg::DIAG_WRITE);

  // index 0 is AR load and read, index 1 is add.
  assign loadEn = diagStrobe && selected && isWrite && (index == 2'd0);
  assign addEn = diagStrobe && selected && isWrite && (index == 2'd1);
  assign readEn = selected && !isWrite && (index == 2'd0);

  assign carry[0] = 1'b0;

  for (genvar i = 0; i < ebusPkg::NUM_SLICES; i++)
  begin : gSlice
    dpSlice uSlice
    (
      .clk      (clk),
      .rstN     (rstN),
      .loadEn   (loadEn),
      .addEn    (addEn),
      .readEn   (readEn),
      .inBits   (ebusData[i*ebusPkg::SLICE_WIDTH +: ebusPkg::SLICE_WIDTH]),
      .carryIn  (carry[i]),
      .carryOut (carry[i+1]),
      .driving  (sliceDriving[i]),
      .outBits  (data[i*ebusPkg::SLICE_WIDTH +: ebusPkg::SLICE_WIDTH])
    );
  end

endmodule

/* hw/ebusMux.sv */
`timescale 1ns/10ps

module ebusMux
(
  input  logic                            feDriving,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  feData,
  input  logic                            aprDriving,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  aprData,
  input  logic                            conDriving,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  conData,
  input  logic [ebusPkg::NUM_SLICES-1:0]  edpSliceDriving,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  edpData,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  ebusData
);

  logic [ebusPkg::EBUS_WIDTH-1:0] edpWord;

  // each slice puts only its own six bits on the bus.
  always_comb
  begin
    for (int i = 0; i < ebusPkg::NUM_SLICES; i++)
    begin
      edpWord[i*ebusPkg::SLICE_WIDTH +: ebusPkg::SLICE_WIDTH] =
        edpSliceDriving[i] ? edpData[i*ebusPkg::SLICE_WIDTH +: ebusPkg::SLICE_WIDTH] : '0;
    end
  end

  always_comb
  begin
    if (feDriving)
      ebusData = feData;
    else if (aprDriving)
      ebusData = aprData;
    else if (conDriving)
      ebusData = conData;
    else if (|edpSliceDriving)
      ebusData = edpWord;
    else
      ebusData = '0;  // idle bus.
  end

endmodule

/* hw/feDiagPort.sv */
`timescale 1ns/10ps

module feDiagPort
(
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            cmdStart,
  input  logic [ebusPkg::DS_WIDTH-1:0]    cmdDs,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  cmdData,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  ebusData,
  output logic [ebusPkg::DS_WIDTH-1:0]    ds,
  output logic                            diagStrobe,
  output logic                            feDriving,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  feData,
  output logic                            busy,
  output logic                            done,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  rdData
);

  typedef enum logic [1:0]
  {
    IDLE,
    SETUP,
    STROBE,
    CAPTURE
  } stateE;

  stateE state;
  logic accept;
  logic isWrite;

  assign accept = (state == IDLE) && cmdStart;
  assign isWrite = (ebusPkg::dsOp(ds) == ebusPkg::DIAG_WRITE);

  assign busy = (state != IDLE);
  assign diagStrobe = (state == STROBE);
  assign feDriving = busy && isWrite;  // front end owns the bus on writes.

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state <= IDLE;
      ds <= '0;
      done <= 1'b0;
      rdData <= '0;
    end
    else
    begin
      done <= 1'b0;
      unique case (state)
        IDLE:
        begin
          if (cmdStart)
          begin
            ds <= cmdDs;
            state <= SETUP;
          end
        end
        SETUP:
        begin
          state <= STROBE;
        end
        STROBE:
        begin
          state <= CAPTURE;  // writes land at this edge.
        end
        CAPTURE:
        begin
          if (!isWrite)
          begin
            rdData <= ebusData;
          end
          done <= 1'b1;
          state <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  // write data, held for the whole cycle.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      feData <= cmdData;
    end
  end

endmodule

/* hw/ebusSubsys.sv */
`timescale 1ns/10ps

module ebusSubsys
(
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            cmdStart,
  input  logic [ebusPkg::DS_WIDTH-1:0]    cmdDs,
  input  logic [ebusPkg::EBUS_WIDTH-1:0]  cmdData,
  output logic                            busy,
  output logic                            done,
  output logic [ebusPkg::EBUS_WIDTH-1:0]  rdData
);

  logic [ebusPkg::DS_WIDTH-1:0] ds;
  logic diagStrobe;
  logic feDriving;
  logic [ebusPkg::EBUS_WIDTH-1:0] feData;
  logic aprDriving;
  logic [ebusPkg::EBUS_WIDTH-1:0] aprData;
  logic conDriving;
  logic [ebusPkg::EBUS_WIDTH-1:0] conData;
  logic [ebusPkg::NUM_SLICES-1:0] edpSliceDriving;
  logic [ebusPkg::EBUS_WIDTH-1:0] edpData;
  logic [ebusPkg::EBUS_WIDTH-1:0] ebusData;

  feDiagPort uFe
  (
    .clk        (clk),
    .rstN       (rstN),
    .cmdStart   (cmdStart),
    .cmdDs      (cmdDs),
    .cmdData    (cmdData),
    .ebusData   (ebusData),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .feDriving  (feDriving),
    .feData     (feData),
    .busy       (busy),
    .done       (done),
    .rdData     (rdData)
  );

  diagRegBoard #(.boardSel(ebusPkg::BOARD_APR)) uApr
  (
    .clk        (clk),
    .rstN       (rstN),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .ebusData   (ebusData),
    .driving    (aprDriving),
    .data       (aprData)
  );

  diagRegBoard #(.boardSel(ebusPkg::BOARD_CON)) uCon
  (
    .clk        (clk),
    .rstN       (rstN),
    .ds         (ds),
    .diagStrobe (diagStrobe),
    .ebusData   (ebusData),
    .driving    (conDriving),
    .data       (conData)
  );

  edpBoard uEdp
  (
    .clk          (clk),
    .rstN         (rstN),
    .ds           (ds),
    .diagStrobe   (diagStrobe),
    .ebusData     (ebusData),
    .sliceDriving (edpSliceDriving),
    .data         (edpData)
  );

  ebusMux uMux
  (
    .feDriving       (feDriving),
    .feData          (feData),
    .aprDriving      (aprDriving),
    .aprData         (aprData),
    .conDriving      (conDriving),
    .conData         (conData),
    .edpSliceDriving (edpSliceDriving),
    .edpData         (edpData),
    .ebusData        (ebusData)
  );

endmodule

/* verification/ebusBus_assertions.sv */
`timescale 1ns/10ps

module ebusBusAssertions
(
  input logic                         clk,
  input logic                         rstN,
  input logic                         cmdStart,
  input logic [ebusPkg::DS_WIDTH-1:0] cmdDs,
  input logic [ebusPkg::DS_WIDTH-1:0] ds,
  input logic                         diagStrobe,
  input logic                         feDriving,
  input logic                         busy,
  input logic                         done,
  input logic                         aprDriving,
  input logic                         conDriving
);

  logic readCmd;

  // direction of the command in flight, taken from the request.
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      readCmd <= 1'b0;
    end
    else if (cmdStart && !busy)
    begin
      readCmd <= !cmdDs[3];  // bit 3 clear is a read.
    end
  end

  doneOnePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // strobe follows a set-up cycle with ds already held.
  strobeInCycle: assert property (@(posedge clk) disable iff (!rstN)
                                  diagStrobe |-> $past(busy) && $stable(ds))
    else $error("diagStrobe without a set-up cycle of the same command");

  feOnlyOnWrite: assert property (@(posedge clk) disable iff (!rstN) feDriving |-> !readCmd)
    else $error("front end drives the bus during a read");

  oneRegBoard: assert property (@(posedge clk) disable iff (!rstN) !(aprDriving && conDriving))
    else $error("both register boards drive the bus");

endmodule

// subsystem scope sees the sequencer outputs and the mux inputs together.
bind ebusSubsys ebusBusAssertions uBusAssertions
(
  .clk        (clk),
  .rstN       (rstN),
  .cmdStart   (cmdStart),
  .cmdDs      (cmdDs),
  .ds         (ds),
  .diagStrobe (diagStrobe),
  .feDriving  (feDriving),
  .busy       (busy),
  .done       (done),
  .aprDriving (aprDriving),
  .conDriving (conDriving)
);

/* verification/ebusTb.sv */
`timescale 1ns/10ps

module ebusTb;

  localparam int W = ebusPkg::EBUS_WIDTH;
  localparam int DW = ebusPkg::DS_WIDTH;
  localparam int TIMEOUT = 20;  // cycles per command.

  logic clk;
  logic rstN;
  logic cmdStart;
  logic [DW-1:0] cmdDs;
  logic [W-1:0] cmdData;
  logic busy;
  logic done;
  logic [W-1:0] rdData;

  // reference copies of the board registers and AR.
  logic [W-1:0] aprModel [4];
  logic [W-1:0] conModel [4];
  logic [W-1:0] arModel;
  integer seed;
  int testErrors;
  int testsOk;
  int testsBad;
  int latency;
  bit timedOut;

  ebusSubsys u_dut
  (
    .clk      (clk),
    .rstN     (rstN),
    .cmdStart (cmdStart),
    .cmdDs    (cmdDs),
    .cmdData  (cmdData),
    .busy     (busy),
    .done     (done),
    .rdData   (rdData)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  function automatic logic [DW-1:0] makeDs(input logic [2:0] board, input ebusPkg::diagOpE op,
                                           input logic [1:0] idx);
    return {board, op, 1'b0, idx};
  endfunction

  function automatic logic [W-1:0] randWord();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[W-1:0];
  endfunction

  function automatic logic [W-1:0] modelRead(input logic [DW-1:0] ds);
    if (ds[6:4] == ebusPkg::BOARD_APR)
      return aprModel[ds[1:0]];
    if (ds[6:4] == ebusPkg::BOARD_CON)
      return conModel[ds[1:0]];
    if (ds[6:4] == ebusPkg::BOARD_EDP && ds[1:0] == 2'd0)
      return arModel;
    return '0;  // unpopulated, or no function.
  endfunction

  task automatic modelWrite(input logic [DW-1:0] ds, input logic [W-1:0] data);
    if (ds[6:4] == ebusPkg::BOARD_APR)
      aprModel[ds[1:0]] = data;
    else if (ds[6:4] == ebusPkg::BOARD_CON)
      conModel[ds[1:0]] = data;
    else if (ds[6:4] == ebusPkg::BOARD_EDP && ds[1:0] == 2'd0)
      arModel = data;
    else if (ds[6:4] == ebusPkg::BOARD_EDP && ds[1:0] == 2'd1)
      arModel = arModel + data;  // wraps at 2^36.
  endtask

  task automatic checkValue(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
    if (!timedOut && got !== exp)
    begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      testErrors++;
    end
  endtask

  // counts negedges from the one after the accepting edge.
  task automatic waitDone(input logic [DW-1:0] ds);
    int n;
    n = 0;
    while (!done && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    latency = n;
    if (!done)
    begin
      $display("timeout: no done within %0d cycles for ds %h", TIMEOUT, ds);
      timedOut = 1'b1;
      testErrors++;
    end
  endtask

  task automatic runCmd(input logic [DW-1:0] ds, input logic [W-1:0] data, output logic [W-1:0] rd);
    rd = '0;
    if (!timedOut)
    begin
      @(negedge clk);
      cmdStart = 1'b1;
      cmdDs = ds;
      cmdData = data;
      @(negedge clk);
      cmdStart = 1'b0;
      waitDone(ds);
      rd = rdData;
      if (ds[3])
        modelWrite(ds, data);
    end
  endtask

  task automatic readCheck(input logic [DW-1:0] ds);
    logic [W-1:0] rd;
    runCmd(ds, '0, rd);
    checkValue($sformatf("rdData ds=%h", ds), rd, modelRead(ds));
  endtask

  task automatic endTest(input string name);
    if (testErrors == 0)
    begin
      $display("test %s: ok", name);
      testsOk++;
    end
    else
    begin
      $display("test %s: %0d errors", name, testErrors);
      testsBad++;
    end
    testErrors = 0;
  endtask

  initial
  begin
    logic [W-1:0] rd;
    logic [DW-1:0] ds;
    int extra;
    seed = 39;
    rstN = 1'b0;
    cmdStart = 1'b0;
    cmdDs = '0;
    cmdData = '0;
    arModel = '0;
    for (int i = 0; i < 4; i++)
    begin
      aprModel[i] = '0;
      conModel[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    checkValue("busy", W'(busy), '0);
    checkValue("done", W'(done), '0);
    checkValue("rdData", rdData, '0);
    for (int b = 1; b <= 3; b++)
      for (int i = 0; i < 4; i++)
        readCheck(makeDs(3'(b), ebusPkg::DIAG_READ, 2'(i)));
    endTest("reset values");

    repeat (12)
    begin
      ds = makeDs(($random(seed) & 1) ? ebusPkg::BOARD_CON : ebusPkg::BOARD_APR,
                  ebusPkg::DIAG_WRITE, 2'($random(seed)));
      runCmd(ds, randWord(), rd);
      readCheck(makeDs(($random(seed) & 1) ? ebusPkg::BOARD_CON : ebusPkg::BOARD_APR,
                       ebusPkg::DIAG_READ, 2'($random(seed))));
    end
    endTest("register write and read");

    runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd0), randWord(), rd);
    repeat (8)
    begin
      runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd1), randWord(), rd);
      readCheck(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_READ, 2'd0));
    end
    // carry out of the low slice, then wrap of the full word.
    runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd0), 36'h00000003f, rd);
    runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd1), 36'h000000001, rd);
    readCheck(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_READ, 2'd0));
    runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd0), 36'hfffffffff, rd);
    runCmd(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_WRITE, 2'd1), 36'h000000001, rd);
    readCheck(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_READ, 2'd0));
    endTest("AR load and add");

    for (int b = 0; b < 8; b++)
    begin
      if (b < 1 || b > 3)
      begin
        runCmd(makeDs(3'(b), ebusPkg::DIAG_WRITE, 2'($random(seed))), randWord(), rd);
        readCheck(makeDs(3'(b), ebusPkg::DIAG_READ, 2'($random(seed))));
      end
    end
    for (int i = 1; i < 4; i++)
      readCheck(makeDs(ebusPkg::BOARD_EDP, ebusPkg::DIAG_READ, 2'(i)));
    for (int b = 1; b <= 3; b++)
      for (int i = 0; i < 4; i++)
        readCheck(makeDs(3'(b), ebusPkg::DIAG_READ, 2'(i)));
    endTest("unpopulated codes");

    // second start arrives while the first command is in its set-up cycle.
    ds = makeDs(ebusPkg::BOARD_APR, ebusPkg::DIAG_WRITE, 2'd2);
    @(negedge clk);
    cmdStart = 1'b1;
    cmdDs = ds;
    cmdData = randWord();
    modelWrite(ds, cmdData);
    @(negedge clk);
    cmdDs = makeDs(ebusPkg::BOARD_CON, ebusPkg::DIAG_WRITE, 2'd3);
    cmdData = randWord();
    @(negedge clk);
    cmdStart = 1'b0;
    waitDone(ds);
    extra = 0;
    repeat (4)
    begin
      @(negedge clk);
      if (done)
        extra++;
    end
    checkValue("done pulses", W'(1 + extra), W'(1));
    checkValue("busy", W'(busy), '0);
    readCheck(makeDs(ebusPkg::BOARD_APR, ebusPkg::DIAG_READ, 2'd2));
    readCheck(makeDs(ebusPkg::BOARD_CON, ebusPkg::DIAG_READ, 2'd3));
    endTest("start while busy");

    repeat (6)
    begin
      ds = makeDs(3'($random(seed)), ebusPkg::diagOpE'($random(seed) & 1), 2'($random(seed)));
      runCmd(ds, randWord(), rd);
      checkValue("done latency", W'(latency), W'(3));
    end
    endTest("done latency");

    $display("summary: %0d tests ok, %0d with errors", testsOk, testsBad);
    if (testsBad == 0 && !timedOut)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

/* filelist.f */
hw/ebusPkg.sv
hw/dpSlice.sv
hw/diagRegBoard.sv
hw/edpBoard.sv
hw/ebusMux.sv
hw/feDiagPort.sv
hw/ebusSubsys.sv
verification/ebusBus_assertions.sv
verification/ebusTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= ebusTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
